/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int xlen           = 32;
    localparam int reg_addr_width = 5;

    typedef logic [6:0] opcode_t;

    localparam opcode_t op_r      = 7'b0110011;
    localparam opcode_t op_i_alu  = 7'b0010011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_system = 7'b1110011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_addi    = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] funct7_sub = 7'b0100000; // add has all zeros

    localparam logic [xlen-1:0] inst_ebreak = 32'h0010_0073;

    // lsb of each instruction field
    localparam int rd_base     = 7;
    localparam int funct3_base = 12;
    localparam int rs1_base    = 15;
    localparam int rs2_base    = 20;
    localparam int funct7_base = 25;

endpackage

/* hw/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_and = 2'd2
    } alu_op_t;

    typedef enum logic [1:0] {
        imm_i = 2'd0,
        imm_b = 2'd1,
        imm_j = 2'd2,
        imm_u = 2'd3
    } imm_op_t;

    // operand pair fed to the alu
    typedef enum logic [1:0] {
        src_reg = 2'd0, // rs1, rs2
        src_imm = 2'd1, // rs1, imm
        src_pc4 = 2'd2  // pc, 4
    } alu_src_t;

endpackage

/* hw/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder #(
    parameter int num_regs = 32
) (
    input  logic [rv_isa_pkg::xlen-1:0]           inst,
    output logic                                  branch,
    output logic                                  jump,
    output logic                                  reg_wen,
    output logic [rv_isa_pkg::reg_addr_width-1:0] reg_waddr,
    output logic [rv_isa_pkg::reg_addr_width-1:0] rs1_addr,
    output logic [rv_isa_pkg::reg_addr_width-1:0] rs2_addr,
    output core_ctrl_pkg::imm_op_t                imm_op,
    output core_ctrl_pkg::alu_op_t                alu_op,
    output core_ctrl_pkg::alu_src_t               alu_src,
    output logic                                  ebreak,
    output logic                                  illegal
);

    rv_isa_pkg::opcode_t                   opcode;
    logic [2:0]                            funct3;
    logic [6:0]                            funct7;
    logic [rv_isa_pkg::reg_addr_width-1:0] rd;
    logic [rv_isa_pkg::reg_addr_width-1:0] rs1;
    logic [rv_isa_pkg::reg_addr_width-1:0] rs2;

    assign opcode = inst[6:0];
    assign funct3 = inst[rv_isa_pkg::funct3_base +: 3];
    assign funct7 = inst[rv_isa_pkg::funct7_base +: 7];
    assign rd     = inst[rv_isa_pkg::rd_base +: rv_isa_pkg::reg_addr_width];
    assign rs1    = inst[rv_isa_pkg::rs1_base +: rv_isa_pkg::reg_addr_width];
    assign rs2    = inst[rv_isa_pkg::rs2_base +: rv_isa_pkg::reg_addr_width];

    always_comb begin
        branch    = 1'b0;
        jump      = 1'b0;
        reg_wen   = 1'b0;
        reg_waddr = '0;
        rs1_addr  = '0;
        rs2_addr  = '0;
        imm_op    = core_ctrl_pkg::imm_i;
        alu_op    = core_ctrl_pkg::alu_add;
        alu_src   = core_ctrl_pkg::src_reg;
        ebreak    = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            rv_isa_pkg::op_r: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                rs1_addr  = rs1;
                rs2_addr  = rs2;
                if (funct3 != rv_isa_pkg::f3_add_sub)
                    illegal = 1'b1;
                else if (funct7 == rv_isa_pkg::funct7_sub)
                    alu_op = core_ctrl_pkg::alu_sub;
                else if (funct7 != 7'b0)
                    illegal = 1'b1;
            end
            rv_isa_pkg::op_i_alu: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                rs1_addr  = rs1;
                alu_src   = core_ctrl_pkg::src_imm;
                if (funct3 != rv_isa_pkg::f3_addi)
                    illegal = 1'b1;
            end
            rv_isa_pkg::op_branch: begin
                branch   = 1'b1;
                rs1_addr = rs1;
                rs2_addr = rs2;
                imm_op   = core_ctrl_pkg::imm_b;
                alu_op   = core_ctrl_pkg::alu_sub; // zero flag means equal
                if (funct3 != rv_isa_pkg::f3_bne)
                    illegal = 1'b1;
            end
            rv_isa_pkg::op_jal: begin
                jump      = 1'b1;
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_op    = core_ctrl_pkg::imm_j;
                alu_src   = core_ctrl_pkg::src_pc4; // link value
            end
            rv_isa_pkg::op_lui: begin
                reg_wen   = 1'b1;
                reg_waddr = rd;
                imm_op    = core_ctrl_pkg::imm_u;
                alu_src   = core_ctrl_pkg::src_imm; // x0 + imm
            end
            rv_isa_pkg::op_system: begin
                if (inst == rv_isa_pkg::inst_ebreak)
                    ebreak = 1'b1;
                else
                    illegal = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
        // rv32e has only 16 registers
        if (reg_waddr >= num_regs || rs1_addr >= num_regs || rs2_addr >= num_regs)
            illegal = 1'b1;
        if (illegal) begin
            branch    = 1'b0;
            jump      = 1'b0;
            reg_wen   = 1'b0;
            reg_waddr = '0;
            rs1_addr  = '0;
            rs2_addr  = '0;
        end
        if (reg_waddr == '0)
            reg_wen = 1'b0;
    end

endmodule

/* hw/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen (
    input  logic [rv_isa_pkg::xlen-1:0] inst,
    input  core_ctrl_pkg::imm_op_t      imm_op,
    output logic [rv_isa_pkg::xlen-1:0] imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (imm_op)
            core_ctrl_pkg::imm_i:
                imm = {{20{sign}}, inst[31:20]};
            core_ctrl_pkg::imm_b:
                imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            core_ctrl_pkg::imm_j:
                imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            core_ctrl_pkg::imm_u:
                imm = {inst[31:12], 12'b0}; // upper 20 bits
            default:
                imm = '0;
        endcase
    end

endmodule

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [rv_isa_pkg::xlen-1:0] a,
    input  logic [rv_isa_pkg::xlen-1:0] b,
    input  core_ctrl_pkg::alu_op_t      op,
    output logic [rv_isa_pkg::xlen-1:0] result,
    output logic                        zero
);

    always_comb begin
        case (op)
            core_ctrl_pkg::alu_add: result = a + b;
            core_ctrl_pkg::alu_sub: result = a - b;
            core_ctrl_pkg::alu_and: result = a & b;
            default:                result = '0;
        endcase
    end

    assign zero = (result == '0); // bne takes the branch when low

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
    parameter int num_regs = 32
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [rv_isa_pkg::reg_addr_width-1:0] raddr1,
    input  logic [rv_isa_pkg::reg_addr_width-1:0] raddr2,
    output logic [rv_isa_pkg::xlen-1:0]           rdata1,
    output logic [rv_isa_pkg::xlen-1:0]           rdata2,
    input  logic                                  wen,
    input  logic [rv_isa_pkg::reg_addr_width-1:0] waddr,
    input  logic [rv_isa_pkg::xlen-1:0]           wdata
);

    logic [rv_isa_pkg::xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++)
                regs[i] <= '0;
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    no_write_x0: assert property (
        @(posedge clk) disable iff (reset) wen |-> (waddr != '0)
    );

endmodule

/* hw/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        halted,
    input  logic                        ack,
    input  logic                        branch,
    input  logic                        jump,
    input  logic                        zero,
    input  logic [rv_isa_pkg::xlen-1:0] imm,
    output logic [rv_isa_pkg::xlen-1:0] pc,
    output logic                        cyc,
    output logic                        stb
);

    logic                        take_target;
    logic [rv_isa_pkg::xlen-1:0] next_pc;

    // wishbone classic with one request per instruction
    assign cyc = !halted;
    assign stb = !halted;

    assign take_target = jump || (branch && !zero);
    assign next_pc     = take_target ? pc + imm : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= reset_pc;
        else if (stb && ack)
            pc <= next_pc; // new address shows next cycle
    end

    // slave may only ack an active strobe
    ack_needs_stb: assert property (
        @(posedge clk) disable iff (reset) ack |-> stb
    );

endmodule

/* hw/core_status.sv */
`timescale 1ns/1ps

module core_status (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ack,
    input  logic                        ebreak,
    input  logic                        illegal,
    input  logic [rv_isa_pkg::xlen-1:0] inst,
    output logic                        halted,
    output logic                        illegal_flag,
    output logic [rv_isa_pkg::xlen-1:0] illegal_inst,
    output logic [31:0]                 retired_count
);

    always_ff @(posedge clk) begin
        if (reset) begin
            halted        <= 1'b0;
            illegal_flag  <= 1'b0;
            retired_count <= '0;
        end else if (ack) begin
            if (ebreak || illegal)
                halted <= 1'b1; // sticky until reset
            if (illegal)
                illegal_flag <= 1'b1;
            else
                retired_count <= retired_count + 32'd1; // ebreak included
        end
    end

    always_ff @(posedge clk) begin
        if (ack && illegal)
            illegal_inst <= inst;
    end

endmodule

/* hw/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter logic [31:0] reset_pc = 32'h0,
    parameter int          num_regs = 32
) (
    input  logic                                  clk,
    input  logic                                  reset,
    output logic                                  ibus_cyc,
    output logic                                  ibus_stb,
    output logic [rv_isa_pkg::xlen-1:0]           ibus_adr,
    output logic                                  ibus_we,
    input  logic [rv_isa_pkg::xlen-1:0]           ibus_dat_i,
    input  logic                                  ibus_ack,
    output logic                                  retire_valid,
    output logic [rv_isa_pkg::xlen-1:0]           retire_pc,
    output logic [rv_isa_pkg::reg_addr_width-1:0] retire_rd,
    output logic [rv_isa_pkg::xlen-1:0]           retire_value,
    output logic                                  retire_wen,
    output logic                                  halted,
    output logic                                  illegal,
    output logic [rv_isa_pkg::xlen-1:0]           illegal_inst,
    output logic [31:0]                           retired_count
);

    logic                                  fire;
    logic                                  branch;
    logic                                  jump;
    logic                                  reg_wen;
    logic [rv_isa_pkg::reg_addr_width-1:0] reg_waddr;
    logic [rv_isa_pkg::reg_addr_width-1:0] rs1_addr;
    logic [rv_isa_pkg::reg_addr_width-1:0] rs2_addr;
    core_ctrl_pkg::imm_op_t                imm_op;
    core_ctrl_pkg::alu_op_t                alu_op;
    core_ctrl_pkg::alu_src_t               alu_src;
    logic                                  ebreak;
    logic                                  dec_illegal;
    logic [rv_isa_pkg::xlen-1:0]           imm;
    logic [rv_isa_pkg::xlen-1:0]           rdata1;
    logic [rv_isa_pkg::xlen-1:0]           rdata2;
    logic [rv_isa_pkg::xlen-1:0]           op_a;
    logic [rv_isa_pkg::xlen-1:0]           op_b;
    logic [rv_isa_pkg::xlen-1:0]           alu_result;
    logic                                  alu_zero;
    logic [rv_isa_pkg::xlen-1:0]           pc;

    assign fire     = ibus_stb && ibus_ack; // instruction valid only here
    assign ibus_adr = pc;
    assign ibus_we  = 1'b0;

    inst_decoder #(.num_regs(num_regs)) decoder_i (
        .inst(ibus_dat_i), .branch(branch), .jump(jump),
        .reg_wen(reg_wen), .reg_waddr(reg_waddr),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .imm_op(imm_op), .alu_op(alu_op), .alu_src(alu_src),
        .ebreak(ebreak), .illegal(dec_illegal)
    );

    imm_gen imm_gen_i (.inst(ibus_dat_i), .imm_op(imm_op), .imm(imm));

    reg_file #(.num_regs(num_regs)) reg_file_i (
        .clk(clk), .reset(reset),
        .raddr1(rs1_addr), .raddr2(rs2_addr),
        .rdata1(rdata1), .rdata2(rdata2),
        .wen(fire && reg_wen), .waddr(reg_waddr), .wdata(alu_result)
    );

    always_comb begin
        case (alu_src)
            core_ctrl_pkg::src_imm: begin
                op_a = rdata1;
                op_b = imm;
            end
            core_ctrl_pkg::src_pc4: begin
                op_a = pc;
                op_b = 32'd4;
            end
            default: begin
                op_a = rdata1;
                op_b = rdata2;
            end
        endcase
    end

    alu alu_i (.a(op_a), .b(op_b), .op(alu_op), .result(alu_result), .zero(alu_zero));

    fetch_unit #(.reset_pc(reset_pc)) fetch_i (
        .clk(clk), .reset(reset), .halted(halted), .ack(ibus_ack),
        .branch(branch), .jump(jump), .zero(alu_zero), .imm(imm),
        .pc(pc), .cyc(ibus_cyc), .stb(ibus_stb)
    );

    core_status status_i (
        .clk(clk), .reset(reset), .ack(fire), .ebreak(ebreak),
        .illegal(dec_illegal), .inst(ibus_dat_i), .halted(halted),
        .illegal_flag(illegal), .illegal_inst(illegal_inst),
        .retired_count(retired_count)
    );

    assign retire_valid = fire && !dec_illegal;
    assign retire_pc    = pc;
    assign retire_rd    = reg_waddr;
    assign retire_value = alu_result;
    assign retire_wen   = fire && reg_wen; // same enable as the register file

endmodule

/* bench/rv_core_tests.svh */
function automatic logic [31:0] r_type_word(int f7, int rs2, int rs1, int f3, int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_isa_pkg::op_r};
endfunction

function automatic logic [31:0] addi_word(int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], rv_isa_pkg::f3_addi, rd[4:0], rv_isa_pkg::op_i_alu};
endfunction

function automatic logic [31:0] bne_word(int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], rv_isa_pkg::f3_bne, off[4:1], off[11],
            rv_isa_pkg::op_branch};
endfunction

function automatic logic [31:0] jal_word(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_isa_pkg::op_jal};
endfunction

function automatic logic [31:0] lui_word(int rd, int imm);
    return {imm[19:0], rd[4:0], rv_isa_pkg::op_lui};
endfunction

task build_arith;
    prog.delete();
    prog.push_back(addi_word(1, 0, 5));
    prog.push_back(addi_word(2, 0, -3));
    prog.push_back(r_type_word(0, 2, 1, rv_isa_pkg::f3_add_sub, 3));
    prog.push_back(r_type_word(rv_isa_pkg::funct7_sub, 2, 1, rv_isa_pkg::f3_add_sub, 4));
    prog.push_back(addi_word(0, 1, 7)); // retire_wen stays low
    prog.push_back(r_type_word(rv_isa_pkg::funct7_sub, 3, 4, rv_isa_pkg::f3_add_sub, 5));
    prog.push_back(rv_isa_pkg::inst_ebreak);
endtask

task build_lui_jal;
    prog.delete();
    prog.push_back(lui_word(5, 20'habcde));
    prog.push_back(jal_word(6, 8));
    prog.push_back(32'h0); // jumped over
    prog.push_back(addi_word(7, 5, 12'h123));
    prog.push_back(jal_word(0, 8));
    prog.push_back(32'h0);
    prog.push_back(rv_isa_pkg::inst_ebreak);
endtask

task build_bne;
    prog.delete();
    prog.push_back(addi_word(1, 0, 3));
    prog.push_back(addi_word(2, 2, 5));
    prog.push_back(addi_word(1, 1, -1));
    prog.push_back(bne_word(1, 0, -8)); // loops back twice
    prog.push_back(bne_word(0, 0, 8));
    prog.push_back(bne_word(2, 0, 8));
    prog.push_back(32'h0);
    prog.push_back(rv_isa_pkg::inst_ebreak);
endtask

task arith_test;
    max_wait = 0;
    build_arith();
    run_program();
endtask

task lui_jal_test;
    max_wait = 0;
    build_lui_jal();
    run_program();
endtask

task bne_test;
    max_wait = 0;
    build_bne();
    run_program();
endtask

task ebreak_test;
    max_wait = 0;
    prog.delete();
    prog.push_back(addi_word(1, 0, 1));
    prog.push_back(r_type_word(0, 1, 1, rv_isa_pkg::f3_add_sub, 2));
    prog.push_back(r_type_word(rv_isa_pkg::funct7_sub, 1, 2, rv_isa_pkg::f3_add_sub, 3));
    prog.push_back(rv_isa_pkg::inst_ebreak);
    run_program();
    check_flag("halted", halted, 1'b1);
    check_word("retired_count", retired_count, 32'd4);
endtask

task illegal_test;
    logic [31:0] bad_word;
    max_wait = 0;
    bad_word = r_type_word(0, 1, 1, 3'b111, 5); // and x5, x1, x1
    prog.delete();
    prog.push_back(addi_word(1, 0, 9));
    prog.push_back(bad_word);
    prog.push_back(rv_isa_pkg::inst_ebreak);
    run_program();
    check_flag("illegal", illegal, 1'b1);
    check_word("illegal_inst", illegal_inst, bad_word);
    check_word("retired_count", retired_count, 32'd1);
endtask

task wait_state_test;
    max_wait = 3;
    build_arith();
    run_program();
    build_bne();
    run_program();
    build_lui_jal();
    run_program();
endtask

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

    localparam int max_cycles = 4000; // longest program at three wait states plus margin

    logic                                  clk;
    logic                                  reset;
    logic                                  ibus_cyc;
    logic                                  ibus_stb;
    logic [rv_isa_pkg::xlen-1:0]           ibus_adr;
    logic                                  ibus_we;
    logic [rv_isa_pkg::xlen-1:0]           ibus_dat_i;
    logic                                  ibus_ack;
    logic                                  retire_valid;
    logic [rv_isa_pkg::xlen-1:0]           retire_pc;
    logic [rv_isa_pkg::reg_addr_width-1:0] retire_rd;
    logic [rv_isa_pkg::xlen-1:0]           retire_value;
    logic                                  retire_wen;
    logic                                  halted;
    logic                                  illegal;
    logic [rv_isa_pkg::xlen-1:0]           illegal_inst;
    logic [31:0]                           retired_count;

    logic [31:0] imem [0:63];
    logic [31:0] prog [$];
    int          max_wait;
    int          wait_left;
    int          cycle_count;
    int unsigned seed_val;

    // reference model state
    logic [31:0] m_pc;
    logic [31:0] m_regs [32];
    logic [31:0] m_retired;
    logic        m_halted;
    logic        m_illegal;
    logic [31:0] m_bad_word;

    rv_core dut_i (
        .clk(clk), .reset(reset), .ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb),
        .ibus_adr(ibus_adr), .ibus_we(ibus_we), .ibus_dat_i(ibus_dat_i), .ibus_ack(ibus_ack),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_value(retire_value), .retire_wen(retire_wen), .halted(halted),
        .illegal(illegal), .illegal_inst(illegal_inst), .retired_count(retired_count)
    );

    always #20 clk = ~clk;

    // wishbone slave with a registered ack after random wait states
    always @(posedge clk) begin
        if (reset) begin
            ibus_ack  <= 1'b0;
            wait_left <= $urandom % (max_wait + 1);
        end else if (ibus_ack) begin
            ibus_ack  <= 1'b0;
            wait_left <= $urandom % (max_wait + 1);
        end else if (ibus_cyc && ibus_stb) begin
            if (wait_left == 0) begin
                ibus_ack   <= 1'b1;
                ibus_dat_i <= imem[ibus_adr[7:2]];
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles, the core never finished its program", max_cycles);
            abort_run();
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    task abort_run;
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task check_word(input string name, input logic [rv_isa_pkg::xlen-1:0] got,
                    input logic [rv_isa_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task check_reg_idx(input string name, input logic [rv_isa_pkg::reg_addr_width-1:0] got,
                       input logic [rv_isa_pkg::reg_addr_width-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task load_program;
        for (int i = 0; i < 64; i++)
            imem[i] = {i[24:0], 7'h7f}; // unknown opcode everywhere
        foreach (prog[i])
            imem[i] = prog[i];
    endtask

    task apply_reset;
        @(posedge clk);
        reset <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        m_pc       = 32'h0;
        m_retired  = 32'h0;
        m_halted   = 1'b0;
        m_illegal  = 1'b0;
        m_bad_word = 32'h0;
        for (int i = 0; i < 32; i++)
            m_regs[i] = 32'h0;
        @(negedge clk);
        check_word("ibus_adr", ibus_adr, 32'h0);
        check_flag("ibus_cyc", ibus_cyc, 1'b1);
        check_flag("retire_valid", retire_valid, 1'b0);
        check_flag("halted", halted, 1'b0);
        check_flag("illegal", illegal, 1'b0);
        check_word("retired_count", retired_count, 32'h0);
    endtask

    task automatic model_retire;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] next_pc;
        logic        wr;
        logic        wen;
        logic        bad;
        logic        stop;
        w       = imem[m_pc[7:2]];
        a       = m_regs[w[19:15]];
        b       = m_regs[w[24:20]];
        val     = 32'h0;
        next_pc = m_pc + 32'd4;
        wr      = 1'b0;
        bad     = 1'b0;
        stop    = 1'b0;
        case (w[6:0])
            rv_isa_pkg::op_r: begin
                wr  = (w[14:12] == rv_isa_pkg::f3_add_sub) &&
                      (w[31:25] == 7'h00 || w[31:25] == rv_isa_pkg::funct7_sub);
                bad = !wr;
                val = w[30] ? a - b : a + b;
            end
            rv_isa_pkg::op_i_alu: begin
                wr  = (w[14:12] == rv_isa_pkg::f3_addi);
                bad = !wr;
                val = a + {{20{w[31]}}, w[31:20]};
            end
            rv_isa_pkg::op_branch: begin
                bad = (w[14:12] != rv_isa_pkg::f3_bne);
                if (a != b)
                    next_pc = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            rv_isa_pkg::op_jal: begin
                wr      = 1'b1;
                val     = m_pc + 32'd4;
                next_pc = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            rv_isa_pkg::op_lui: begin
                wr  = 1'b1;
                val = {w[31:12], 12'h0};
            end
            default: begin
                stop = (w == rv_isa_pkg::inst_ebreak);
                bad  = !stop;
            end
        endcase
        wen = wr && (w[11:7] != 5'd0); // x0 never written
        check_flag("retire_valid", retire_valid, !bad);
        check_flag("retire_wen", retire_wen, wen);
        if (!bad) begin
            check_word("retire_pc", retire_pc, m_pc);
            check_reg_idx("retire_rd", retire_rd, wr ? w[11:7] : 5'd0);
            m_retired = m_retired + 32'd1;
        end
        if (wen) begin
            check_word("retire_value", retire_value, val);
            m_regs[w[11:7]] = val;
        end
        m_pc      = next_pc;
        m_halted  = bad || stop;
        m_illegal = bad;
        if (bad)
            m_bad_word = w;
    endtask

    task observe_cycle;
        check_flag("ibus_stb", ibus_stb, 1'b1);
        check_flag("ibus_we", ibus_we, 1'b0);
        check_word("ibus_adr", ibus_adr, m_pc);
        if (ibus_ack)
            model_retire();
        else
            check_flag("retire_valid", retire_valid, 1'b0);
    endtask

    task run_program;
        load_program();
        apply_reset();
        while (!m_halted) begin
            @(negedge clk);
            observe_cycle();
        end
        @(negedge clk);
        check_flag("halted", halted, 1'b1);
        check_flag("illegal", illegal, m_illegal);
        if (m_illegal)
            check_word("illegal_inst", illegal_inst, m_bad_word);
        check_word("retired_count", retired_count, m_retired);
        repeat (3) begin
            check_flag("ibus_cyc", ibus_cyc, 1'b0);
            check_flag("ibus_stb", ibus_stb, 1'b0);
            @(negedge clk);
        end
    endtask

    `include "rv_core_tests.svh"

    initial begin
        seed_val    = $urandom(81850);
        clk         = 1'b0;
        reset       = 1'b1;
        ibus_ack    = 1'b0;
        ibus_dat_i  = 32'h0;
        max_wait    = 0;
        cycle_count = 0;
        arith_test();
        lui_jal_test();
        bne_test();
        ebreak_test();
        illegal_test();
        wait_state_test();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* project.f */
+incdir+bench
hw/rv_isa_pkg.sv
hw/core_ctrl_pkg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/alu.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/core_status.sv
hw/rv_core.sv
bench/rv_core_tb.sv
